//--- arm_params.svh
`ifndef ARM_PARAMS_SVH
`define ARM_PARAMS_SVH
// Condition field, bits 31 to 28 of every instruction
`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_CS 4'b0010
`define COND_CC 4'b0011
`define COND_MI 4'b0100
`define COND_PL 4'b0101
`define COND_VS 4'b0110
`define COND_VC 4'b0111
`define COND_HI 4'b1000
`define COND_LS 4'b1001
`define COND_GE 4'b1010
`define COND_LT 4'b1011
`define COND_GT 4'b1100
`define COND_LE 4'b1101
`define COND_AL 4'b1110
`define COND_NV 4'b1111
`define COND_MATTERS(c) ((c) != `COND_AL)
`define CPSR_N 31
`define CPSR_Z 30
`define CPSR_C 29
`define CPSR_V 28
`define ALU_AND 4'b0000
`define ALU_EOR 4'b0001
`define ALU_SUB 4'b0010
`define ALU_RSB 4'b0011
`define ALU_ADD 4'b0100
`define ALU_ADC 4'b0101
`define ALU_SBC 4'b0110
`define ALU_RSC 4'b0111
`define ALU_TST 4'b1000
`define ALU_TEQ 4'b1001
`define ALU_CMP 4'b1010
`define ALU_CMN 4'b1011
`define ALU_ORR 4'b1100
`define ALU_MOV 4'b1101
`define ALU_BIC 4'b1110
`define ALU_MVN 4'b1111
`define SHIFT_LSL 2'b00
`define SHIFT_LSR 2'b01
`define SHIFT_ASR 2'b10
`define SHIFT_ROR 2'b11
// Class patterns for casez, listed in the order they must be tried
`define DECODE_ALU_MULT         32'b????_0000_00??_????_????_????_1001_????
`define DECODE_ALU_MRS          32'b????_0001_0?00_1111_????_0000_0000_0000
`define DECODE_ALU_MSR          32'b????_0001_0?10_1001_1111_0000_0000_????
`define DECODE_ALU_MSR_FLAGS    32'b????_00?1_0?10_1000_1111_????_????_????
`define DECODE_ALU_SWP          32'b????_0001_0?00_????_????_0000_1001_????
`define DECODE_ALU_BX           32'b????_0001_0010_1111_1111_1111_0001_????
`define DECODE_ALU_HDATA_REG    32'b????_000?_?0??_????_????_0000_1??1_????
`define DECODE_ALU_HDATA_IMM    32'b????_000?_?1??_????_????_????_1??1_????
`define DECODE_ALU              32'b????_00??_????_????_????_????_????_????
`define DECODE_LDRSTR_UNDEFINED 32'b????_011?_????_????_????_????_???1_????
`define DECODE_LDRSTR           32'b????_01??_????_????_????_????_????_????
`define DECODE_LDMSTM           32'b????_100?_????_????_????_????_????_????
`define DECODE_BRANCH           32'b????_101?_????_????_????_????_????_????
`define DECODE_LDCSTC           32'b????_110?_????_????_????_????_????_????
`define DECODE_CDP              32'b????_1110_????_????_????_????_???0_????
`define DECODE_MRCMCR           32'b????_1110_????_????_????_????_???1_????
`define DECODE_SWI              32'b????_1111_????_????_????_????_????_????
`define NUM_INFLIGHT 2	// Execute and memory; writeback reaches the register file
`endif

//--- arm_pkg.sv
package arm_pkg;
	typedef logic [15:0] reg_mask_t;	// Bit n stands for rn

	// Data-processing and transfer layout
	typedef struct packed
	{
		logic [3:0] cond;
		logic [2:0] cls;
		logic [3:0] opcode;
		logic s;	// Also the L bit of transfers
		logic [3:0] rn;
		logic [3:0] rd;
		logic [3:0] rs;
		logic [3:0] shift;
		logic [3:0] rm;
	} dp_view_t;

	// Multiply swaps the roles of the rn and rd fields
	typedef struct packed
	{
		logic [3:0] cond;
		logic [5:0] cls;
		logic accumulate;
		logic s;
		logic [3:0] rd;
		logic [3:0] rn;
		logic [3:0] rs;
		logic [3:0] fixed;	// Always 1001
		logic [3:0] rm;
	} mul_view_t;

	typedef union packed
	{
		dp_view_t dp_view;
		mul_view_t mul_view;
	} arm_insn_u;

	typedef struct packed
	{
		logic bubble;
		arm_insn_u insn;
		logic [31:0] pc;
	} issue_in_t;

	typedef struct packed
	{
		logic bubble;
		arm_insn_u insn;
		logic [31:0] pc;
	} issue_out_t;

	typedef struct packed
	{
		logic use_cpsr;
		reg_mask_t use_regs;
		logic def_cpsr;
		reg_mask_t def_regs;
	} reg_use_t;
endpackage

//--- cond_check.sv
`include "arm_params.svh"

module cond_check
(
	input logic [3:0] cond,
	input logic [31:0] cpsr,
	output logic condition_met
);
	logic n;
	logic z;
	logic c;
	logic v;

	assign n = cpsr[`CPSR_N];
	assign z = cpsr[`CPSR_Z];
	assign c = cpsr[`CPSR_C];
	assign v = cpsr[`CPSR_V];

	always_comb
	begin
		case (cond)
			`COND_EQ: condition_met = z;
			`COND_NE: condition_met = !z;
			`COND_CS: condition_met = c;
			`COND_CC: condition_met = !c;
			`COND_MI: condition_met = n;
			`COND_PL: condition_met = !n;
			`COND_VS: condition_met = v;
			`COND_VC: condition_met = !v;
			`COND_HI: condition_met = c && !z;	// Unsigned higher
			`COND_LS: condition_met = !c || z;
			`COND_GE: condition_met = n == v;	// Signed compares use N against V
			`COND_LT: condition_met = n != v;
			`COND_GT: condition_met = !z && (n == v);
			`COND_LE: condition_met = z || (n != v);
			`COND_AL: condition_met = 1'b1;
			`COND_NV: condition_met = 1'b0;
		endcase
	end
endmodule

//--- issue_scoreboard.sv
`include "arm_params.svh"

module issue_scoreboard import arm_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic flush,
	input logic condition_met,
	input issue_in_t in,
	input reg_use_t reg_use,
	output issue_out_t out,
	output logic outstall
);
	typedef struct packed
	{
		logic def_cpsr;
		reg_mask_t def_regs;
	} slot_t;

	slot_t [`NUM_INFLIGHT-1:0] slot;	// Slot 0 is in execute, the top one in memory
	slot_t newest;
	logic flush_pending;
	logic flush_now;
	logic wait_cpsr;
	logic wait_regs;
	logic waiting;
	logic kill;

	always_comb
	begin
		wait_cpsr = 1'b0;
		wait_regs = 1'b0;
		for (int i = 0; i < `NUM_INFLIGHT; i++)
		begin
			wait_cpsr |= reg_use.use_cpsr & slot[i].def_cpsr;
			wait_regs |= |(reg_use.use_regs & slot[i].def_regs);
		end
	end

	assign waiting = wait_cpsr | wait_regs;
	// A flush makes the waiting instruction moot, so it no longer holds decode
	assign outstall = stall | (waiting & !in.bubble & !flush);
	assign flush_now = (flush | flush_pending) & !outstall;

	// Anything that does not really issue leaves an empty slot behind
	assign kill = waiting | in.bubble | !condition_met;
	assign newest = kill ? '0 : slot_t'{def_cpsr: reg_use.def_cpsr, def_regs: reg_use.def_regs};

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			flush_pending <= 1'b0;
		else if (flush && outstall)
			flush_pending <= 1'b1;	// Held until the stage can move again
		else if (!outstall)
			flush_pending <= 1'b0;
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			slot <= '0;
		else if (flush_now)
			slot <= '0;
		else if (!stall)
			slot <= {slot[`NUM_INFLIGHT-2:0], newest};
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out.bubble <= 1'b1;
			out.insn <= '0;
			out.pc <= '0;
		end
		else if (flush_now)
			out.bubble <= 1'b1;
		else if (!stall)
		begin
			out.bubble <= kill;
			out.insn <= in.insn;
			out.pc <= in.pc;
		end
	end

	a_reset_bubble: assert property (@(posedge clk) $rose(arst_n) |-> out.bubble)
		else $error("Stage left reset with a live instruction");
	a_stall_holds: assert property (@(posedge clk) disable iff (!arst_n) stall |=> $stable(slot))
		else $error("Scoreboard moved under back-pressure");
endmodule

//--- issue_top.sv
module issue_top import arm_pkg::*;
(
	input logic clk,
	input logic arst_n,
	input logic stall,
	input logic flush,
	input issue_in_t in,
	input logic [31:0] cpsr,
	output issue_out_t out,
	output logic outstall
);
	reg_use_t reg_use;
	logic condition_met;

	reg_use_decode u_decode
	(
		.insn(in.insn),
		.reg_use(reg_use)
	);

	cond_check u_cond
	(
		.cond(in.insn.dp_view.cond),
		.cpsr(cpsr),
		.condition_met(condition_met)
	);

	issue_scoreboard u_scoreboard
	(
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.flush(flush),
		.condition_met(condition_met),
		.in(in),
		.reg_use(reg_use),
		.out(out),
		.outstall(outstall)
	);
endmodule

//--- project.f
+incdir+.
arm_pkg.sv
reg_use_decode.sv
cond_check.sv
issue_scoreboard.sv
issue_top.sv
tb_issue.sv

//--- reg_use_decode.sv
`include "arm_params.svh"

module reg_use_decode import arm_pkg::*;
(
	input arm_insn_u insn,
	output reg_use_t reg_use
);
	logic [31:0] word;
	dp_view_t dp;
	mul_view_t mul;
	logic cond_used;
	logic l_bit;
	logic w_bit;
	logic i_bit;
	reg_mask_t wb_rn;	// Base written back by single transfers
	reg_mask_t list;

	// The PC is always available, so r15 never enters a mask
	function automatic reg_mask_t idx_bit(input logic [3:0] r);
		return (r == 4'd15) ? '0 : reg_mask_t'(1) << r;
	endfunction

	// LSL #0 passes C through and ROR #0 is RRX; register shifts do not count here
	function automatic logic shift_reads_carry(input logic [7:0] sh);
		return !sh[0] && (sh[7:3] == 5'd0)
			&& ((sh[2:1] == `SHIFT_LSL) || (sh[2:1] == `SHIFT_ROR));
	endfunction

	assign word = insn;
	assign dp = insn.dp_view;
	assign mul = insn.mul_view;
	assign cond_used = `COND_MATTERS(dp.cond);
	assign l_bit = dp.s;
	assign w_bit = word[21];
	assign i_bit = word[25];
	assign wb_rn = (!word[24] || w_bit) ? idx_bit(dp.rn) : '0;	// Post-index always writes back
	assign list = word[15:0] & 16'h7fff;

	always_comb
	begin
		reg_use = '0;
		reg_use.use_cpsr = cond_used;
		casez (word)
			`DECODE_ALU_MULT:	// Tried before ALU since it is a corner of that space
			begin
				reg_use.use_regs = idx_bit(mul.rs) | idx_bit(mul.rm)
					| (mul.accumulate ? idx_bit(mul.rn) : '0);
				reg_use.def_cpsr = mul.s;
				reg_use.def_regs = idx_bit(mul.rd);
			end
			`DECODE_ALU_MRS:
			begin
				reg_use.use_cpsr = cond_used | !word[22];	// Reading the SPSR leaves CPSR alone
				reg_use.def_regs = idx_bit(dp.rd);
			end
			`DECODE_ALU_MSR, `DECODE_ALU_MSR_FLAGS:
			begin
				reg_use.use_regs = i_bit ? '0 : idx_bit(dp.rm);
				reg_use.def_cpsr = 1'b1;
			end
			`DECODE_ALU_SWP:
			begin
				reg_use.use_regs = idx_bit(dp.rn) | idx_bit(dp.rm);
				reg_use.def_regs = idx_bit(dp.rd);
			end
			`DECODE_ALU_BX:
				reg_use.use_regs = idx_bit(dp.rm);
			`DECODE_ALU_HDATA_REG, `DECODE_ALU_HDATA_IMM:	// Bit 22 picks the immediate offset
			begin
				reg_use.use_regs = idx_bit(dp.rn) | (word[22] ? '0 : idx_bit(dp.rm))
					| (l_bit ? '0 : idx_bit(dp.rd));
				reg_use.def_regs = wb_rn | (l_bit ? idx_bit(dp.rd) : '0);
			end
			`DECODE_ALU:
			begin
				reg_use.use_cpsr = cond_used
					| (dp.opcode inside {`ALU_ADC, `ALU_SBC, `ALU_RSC})
					| (!i_bit && shift_reads_carry({dp.rs, dp.shift}));
				reg_use.use_regs = (i_bit ? '0 : (idx_bit(dp.rm) | (word[4] ? idx_bit(dp.rs) : '0)))
					| ((dp.opcode inside {`ALU_MOV, `ALU_MVN}) ? '0 : idx_bit(dp.rn));
				reg_use.def_cpsr = dp.s;
				reg_use.def_regs = (dp.opcode inside {`ALU_TST, `ALU_TEQ, `ALU_CMP, `ALU_CMN})
					? '0 : idx_bit(dp.rd);
			end
			`DECODE_LDRSTR_UNDEFINED:
				reg_use.use_cpsr = 1'b0;	// Traps as undefined before anything is read
			`DECODE_LDRSTR:
			begin
				// A scaled register offset can be RRX as well
				reg_use.use_cpsr = cond_used | (i_bit && shift_reads_carry({dp.rs, dp.shift}));
				reg_use.use_regs = idx_bit(dp.rn) | (i_bit ? idx_bit(dp.rm) : '0)
					| (l_bit ? '0 : idx_bit(dp.rd));
				reg_use.def_regs = wb_rn | (l_bit ? idx_bit(dp.rd) : '0);
			end
			`DECODE_LDMSTM:
			begin
				reg_use.use_regs = idx_bit(dp.rn) | (l_bit ? '0 : list);
				reg_use.def_cpsr = word[22];	// LDM with S and r15 restores the CPSR
				reg_use.def_regs = (w_bit ? idx_bit(dp.rn) : '0) | (l_bit ? list : '0);
			end
			`DECODE_BRANCH:
				reg_use.def_regs = word[24] ? idx_bit(4'd14) : '0;	// BL writes the link register
			`DECODE_LDCSTC:
			begin
				reg_use.use_regs = idx_bit(dp.rn);
				reg_use.def_regs = w_bit ? idx_bit(dp.rn) : '0;
			end
			`DECODE_MRCMCR:
			begin
				reg_use.use_regs = l_bit ? '0 : idx_bit(dp.rd);
				reg_use.def_cpsr = l_bit && (dp.rd == 4'd15);	// MRC to r15 lands in the flags
				reg_use.def_regs = l_bit ? idx_bit(dp.rd) : '0;
			end
			`DECODE_CDP, `DECODE_SWI:
			begin
				// Only the condition is read
			end
			default:
				reg_use.use_cpsr = 1'b0;
		endcase
	end

	always_comb
	begin
		assert (!reg_use.def_regs[15])
			else $error("r15 appears in the write mask of %h", word);
	end
endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f project.f --top-module tb_issue -o tb_issue

./obj_dir/tb_issue | tee sim.log

if grep -qF '*** TEST PASSED ***' sim.log
then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

//--- tb_issue.sv
module tb_issue import arm_pkg::*;
();
	typedef struct packed
	{
		logic [31:0] insn;
		logic bubble;
		logic [31:0] cpsr;
		logic stall;
		logic flush;
		logic exp_bubble;	// Value of out.bubble one edge after the row
		logic exp_outstall;	// Value of outstall while the row is applied
	} row_t;

	localparam logic [31:0] z_set = 32'h4000_0000;
	localparam logic [31:0] n_set = 32'h8000_0000;

	logic clk = 1'b0;
	logic arst_n;
	logic stall;
	logic flush;
	logic [31:0] cpsr;
	issue_in_t in_word;
	issue_out_t out_word;
	logic outstall;

	row_t rows[$];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 0;
	logic [31:0] pc_drv = 32'h0000_8000;
	logic [31:0] exp_insn = '0;	// Reset clears the output word
	logic [31:0] exp_pc = '0;
	logic pending = 1'b0;
	logic flush_eff;
	logic last_outstall = 1'b0;
	row_t r;

	issue_top DUT
	(
		.clk(clk),
		.arst_n(arst_n),
		.stall(stall),
		.flush(flush),
		.in(in_word),
		.cpsr(cpsr),
		.out(out_word),
		.outstall(outstall)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
		begin
			$display("Timeout after %0d cycles, the stage seems stuck in a stall", cycles);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	task automatic add_row(input logic [31:0] insn, input logic bubble, input logic [31:0] cp,
		input logic st, input logic fl, input logic eb, input logic eo);
		row_t row;
		row = '{insn, bubble, cp, st, fl, eb, eo};
		rows.push_back(row);
	endtask

	task automatic check_out(input int idx);
		checks++;
		assert (out_word.bubble == rows[idx].exp_bubble)
			else begin
				errors++;
				$display("FAILED at %0t: row %0d out.bubble is %b, expected %b",
					$time, idx, out_word.bubble, rows[idx].exp_bubble);
			end
		assert (out_word.insn == exp_insn && out_word.pc == exp_pc)
			else begin
				errors++;
				$display("FAILED at %0t: row %0d out holds %h at pc %h, expected %h at pc %h",
					$time, idx, out_word.insn, out_word.pc, exp_insn, exp_pc);
			end
	endtask

	initial
	begin
		arst_n = 1'b0;
		stall = 1'b0;
		flush = 1'b0;
		cpsr = '0;
		in_word = '0;
		in_word.bubble = 1'b1;

		// Conditions: EQ met, NE fails, NV never, LT met and GE failed with N set
		add_row(32'h03A01001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'h13A02002, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b0);
		add_row(32'hF3A05005, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b0);
		add_row(32'hB3A02002, 1'b0, n_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hA3A02002, 1'b0, n_set, 1'b0, 1'b0, 1'b1, 1'b0);
		add_row(32'hE3A06006, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
		// MOV r3 then ADD r4, r3, r2 waits two cycles; r15 and r9 readers go straight through
		add_row(32'hE3A03001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE1A0F00E, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);	// MOV pc, lr writes r15
		add_row(32'hE28F7004, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE2898001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		// MOVS followed by ADDEQ, then MOVS followed by an RRX operand
		add_row(32'hE3B01000, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'h02822001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'h02822001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'h02822001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE3B01000, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE1A06069, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE1A06069, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE1A06069, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE3B01000, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE3A05007, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);	// Immediate MOV reads no flags
		// STR reads rd, LDR writes rd, LDM writes its list
		add_row(32'hE3A0A001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE58BA000, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE58BA000, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE58BA000, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE59BC000, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE28C0001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE28C0001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE28C0001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE89B0006, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE2823001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE2823001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE2823001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		// MLA reads its accumulator and writes rd, plain MUL ignores the rn field
		add_row(32'hE3A07003, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE0247695, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0247695, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0247695, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE2840001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE2840001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE2840001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE3A07003, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE0047695, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		// Back-pressure in the middle of a hazard, then on a free instruction
		add_row(32'hE3A03001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0834002, 1'b0, z_set, 1'b1, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0834002, 1'b0, z_set, 1'b1, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b1);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE3A09002, 1'b0, z_set, 1'b1, 1'b0, 1'b0, 1'b1);
		add_row(32'hE3A09002, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		// Flush while issuing, then a flush that arrives under back-pressure
		add_row(32'hE3A03001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b1, 1'b1, 1'b0);
		add_row(32'hE2835001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE3A03001, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'hE3A06001, 1'b0, z_set, 1'b1, 1'b1, 1'b0, 1'b1);
		add_row(32'hE3A06001, 1'b0, z_set, 1'b0, 1'b0, 1'b1, 1'b0);
		add_row(32'hE0834002, 1'b0, z_set, 1'b0, 1'b0, 1'b0, 1'b0);
		add_row(32'h00000000, 1'b1, z_set, 1'b0, 1'b0, 1'b1, 1'b0);
		cycle_limit = 4 * rows.size() + 16;

		repeat (16) @(posedge clk);
		arst_n <= 1'b1;
		@(negedge clk);
		checks++;
		assert (out_word.bubble && out_word.insn == '0 && out_word.pc == '0)
			else begin
				errors++;
				$display("FAILED at %0t: output after reset is not an empty bubble", $time);
			end

		for (int i = 0; i < rows.size(); i++)
		begin
			r = rows[i];
			@(posedge clk);
			// Decode has to hold its word while the stage pushes back
			if (i > 0)
				assert (!last_outstall || (r.insn == rows[i - 1].insn && r.bubble == rows[i - 1].bubble))
					else begin
						errors++;
						$display("Row %0d changes the decode input while outstall is high", i);
					end
			stall <= r.stall;
			flush <= r.flush;
			cpsr <= r.cpsr;
			in_word.bubble <= r.bubble;
			in_word.insn <= r.insn;
			in_word.pc <= pc_drv;
			@(negedge clk);
			if (i > 0)
				check_out(i - 1);
			checks++;
			assert (outstall == r.exp_outstall)
				else begin
					errors++;
					$display("FAILED at %0t: row %0d outstall is %b, expected %b",
						$time, i, outstall, r.exp_outstall);
				end
			last_outstall = outstall;

			// A flush acts only on an edge where the stage is free to move
			flush_eff = (r.flush | pending) & !r.exp_outstall;
			if (r.flush && r.exp_outstall)
				pending = 1'b1;
			else if (!r.exp_outstall)
				pending = 1'b0;
			if (!flush_eff && !r.stall)
			begin
				exp_insn = r.insn;
				exp_pc = pc_drv;
			end
			if (!r.exp_outstall)
				pc_drv = pc_drv + 32'd4;
		end

		@(posedge clk);
		in_word.bubble <= 1'b1;
		stall <= 1'b0;
		flush <= 1'b0;
		@(negedge clk);
		check_out(rows.size() - 1);

		$display("Rows: %0d, checks: %0d, errors: %0d", rows.size(), checks, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end
endmodule
